// File: source/mem_geometry_pkg.sv
`default_nettype none

package mem_geometry_pkg;

    //////////////////////////////
    // Array and lane geometry
    //////////////////////////////

    localparam int MEM_BYTES = 256;
    localparam int LANES     = 4;
    localparam int LANE_W    = 8;

    // Queue depth doubles as the requester's starting credit count
    localparam int REQ_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W     = $clog2(REQ_QUEUE_DEPTH);
    localparam int QUEUE_CNT_W     = $clog2(REQ_QUEUE_DEPTH + 1);

    // Consumer response buffer slots
    localparam int RSP_CREDITS  = 2;
    localparam int RSP_CREDIT_W = $clog2(RSP_CREDITS + 1);

    typedef logic [LANES*LANE_W-1:0] word_t;
    typedef logic [7:0]              byte_addr_t;
    typedef logic [LANE_W-1:0]       mem_byte_t;

    // Encoded value is the byte count minus one
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_HALF  = 2'd1,
        SIZE_THREE = 2'd2,
        SIZE_WORD  = 2'd3
    } access_size_t;

endpackage

`default_nettype wire

// File: source/mem_txn_pkg.sv
`default_nettype none

package mem_txn_pkg;

    //////////////////////////////
    // Load/store transactions
    //////////////////////////////

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_t;

    // One request as it travels from requester to RAM
    typedef struct packed {
        mem_op_t                       op;
        mem_geometry_pkg::access_size_t size;
        logic                          sign;   // sign-extend a short load
        mem_geometry_pkg::byte_addr_t   addr;
        mem_geometry_pkg::word_t        wdata;  // lane 0 in the low byte
    } mem_req_t;

    // Load result, already extended to a full word
    typedef struct packed {
        mem_geometry_pkg::word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/lsu_request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_request_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_txn_pkg::mem_req_t req,
    input  logic                  pop,
    output logic                  head_valid,
    output mem_txn_pkg::mem_req_t head,
    output logic                  req_credit
);

    import mem_geometry_pkg::*;
    import mem_txn_pkg::*;

    mem_req_t                entries [REQ_QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0]  wr_ptr;
    logic [QUEUE_PTR_W-1:0]  rd_ptr;
    logic [QUEUE_CNT_W-1:0]  count;
    logic                    do_pop;

    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];
    assign do_pop     = pop && head_valid;

    // Entry storage, written at the push edge
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            entries[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end
        else
        begin
            if (req_valid)
                wr_ptr <= wr_ptr + QUEUE_PTR_W'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + QUEUE_PTR_W'(1);

            case ({req_valid, do_pop})
                2'b10:   count <= count + QUEUE_CNT_W'(1);
                2'b01:   count <= count - QUEUE_CNT_W'(1);
                default: count <= count;
            endcase

            // Credit goes back the cycle after the entry leaves
            req_credit <= do_pop;
        end
    end

    //////////////////////////////
    // Protocol checks
    //////////////////////////////

    // Requester overran its credits
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(req_valid && count == QUEUE_CNT_W'(REQ_QUEUE_DEPTH)));

endmodule

`default_nettype wire

// File: source/mem_access_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_engine (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  head_valid,
    input  mem_txn_pkg::mem_req_t head,
    input  logic                  rsp_credit,
    output logic                  pop,
    output logic                  access_en,
    output mem_txn_pkg::mem_req_t access_req,
    output logic                  access_is_load
);

    import mem_geometry_pkg::*;
    import mem_txn_pkg::*;

    logic [RSP_CREDIT_W-1:0] credits;
    logic                    head_is_load;
    logic                    load_pop;

    assign head_is_load = (head.op == OP_LOAD);

    // Stores always go; loads wait for a free response slot
    assign pop      = head_valid && (!head_is_load || credits != '0);
    assign load_pop = pop && head_is_load;

    assign access_en      = pop;
    assign access_req     = head;
    assign access_is_load = head_is_load;

    // Response credit counter
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= RSP_CREDIT_W'(RSP_CREDITS);
        end
        else
        begin
            case ({load_pop, rsp_credit})
                2'b10:   credits <= credits - RSP_CREDIT_W'(1);
                2'b01:   credits <= credits + RSP_CREDIT_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    //////////////////////////////
    // Credit checks
    //////////////////////////////

    // Consumer returned more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= RSP_CREDIT_W'(RSP_CREDITS));

    a_no_load_without_credit: assert property (@(posedge clk) disable iff (reset)
        !(access_en && access_is_load && credits == '0));

endmodule

`default_nettype wire

// File: source/byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  access_en,
    input  mem_txn_pkg::mem_req_t access_req,
    input  logic                  access_is_load,
    output logic                  rsp_valid,
    output mem_txn_pkg::mem_rsp_t rsp
);

    import mem_geometry_pkg::*;
    import mem_txn_pkg::*;

    mem_byte_t  mem [MEM_BYTES];

    byte_addr_t lane_addr [LANES];
    mem_byte_t  rd_lane   [LANES];
    logic [2:0] lane_cnt;
    logic [1:0] top_lane;
    logic       fill_bit;
    word_t      load_word;
    logic       do_store;
    logic       do_load;

    assign do_store = access_en && !access_is_load;
    assign do_load  = access_en && access_is_load;

    // Size encoding is byte count minus one
    assign lane_cnt = {1'b0, access_req.size} + 3'd1;
    assign top_lane = access_req.size;

    //////////////////////////////
    // Lane addressing
    //////////////////////////////

    // 8-bit sum wraps past the end of the array
    always_comb
    begin
        for (int k = 0; k < LANES; k++)
        begin
            lane_addr[k] = access_req.addr + byte_addr_t'(k);
            rd_lane[k]   = mem[lane_addr[k]];
        end
    end

    // Masked lane write
    always_ff @(posedge clk)
    begin
        if (do_store)
        begin
            for (int k = 0; k < LANES; k++)
            begin
                if (k < int'(lane_cnt))
                    mem[lane_addr[k]] <= access_req.wdata[k*LANE_W +: LANE_W];
            end
        end
    end

    //////////////////////////////
    // Load extension
    //////////////////////////////

    // A full word covers every lane, so sign has no effect there
    assign fill_bit = access_req.sign && rd_lane[top_lane][LANE_W-1];

    always_comb
    begin
        for (int k = 0; k < LANES; k++)
        begin
            if (k < int'(lane_cnt))
                load_word[k*LANE_W +: LANE_W] = rd_lane[k];
            else
                load_word[k*LANE_W +: LANE_W] = {LANE_W{fill_bit}};
        end
    end

    // Response payload
    always_ff @(posedge clk)
    begin
        if (do_load)
            rsp.rdata <= load_word;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= do_load;
    end

endmodule

`default_nettype wire

// File: source/data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_txn_pkg::mem_req_t req,
    output logic                  req_credit,
    input  logic                  rsp_credit,
    output logic                  rsp_valid,
    output mem_txn_pkg::mem_rsp_t rsp
);

    import mem_txn_pkg::*;

    logic     head_valid;
    mem_req_t head;
    logic     pop;
    logic     access_en;
    mem_req_t access_req;
    logic     access_is_load;

    // In-order request buffer
    lsu_request_queue i_queue (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .pop        (pop),
        .head_valid (head_valid),
        .head       (head),
        .req_credit (req_credit)
    );

    mem_access_engine i_engine (
        .clk            (clk),
        .reset          (reset),
        .head_valid     (head_valid),
        .head           (head),
        .rsp_credit     (rsp_credit),
        .pop            (pop),
        .access_en      (access_en),
        .access_req     (access_req),
        .access_is_load (access_is_load)
    );

    byte_lane_ram i_ram (
        .clk            (clk),
        .reset          (reset),
        .access_en      (access_en),
        .access_req     (access_req),
        .access_is_load (access_is_load),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

endmodule

`default_nettype wire

// File: dv/data_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_txn_pkg::mem_req_t req,
    input  logic                  rsp_valid,
    input  mem_txn_pkg::mem_rsp_t rsp,
    input  logic                  run_end,
    output int                    error_count,
    output int                    loads_pending
);

    import mem_geometry_pkg::*;
    import mem_txn_pkg::*;

    // Byte model of the RAM, updated in request order
    mem_byte_t model [MEM_BYTES];
    word_t     expected_q [$];
    word_t     exp_data;
    int        errors  = 0;
    int        pending = 0;

    assign error_count   = errors;
    assign loads_pending = pending;

    function automatic int byte_count(access_size_t size);
        case (size)
            SIZE_BYTE:  return 1;
            SIZE_HALF:  return 2;
            SIZE_THREE: return 3;
            default:    return 4;
        endcase
    endfunction

    // Little-endian gather with wrap at the array end, then zero or sign fill
    function automatic word_t expected_load(mem_req_t r);
        word_t      val;
        int         nbytes;
        byte_addr_t a;
        val    = '0;
        nbytes = byte_count(r.size);
        for (int i = 0; i < nbytes; i++)
        begin
            a = r.addr + byte_addr_t'(i);
            val[8*i +: 8] = model[a];
        end
        if (r.sign && val[8*nbytes-1])
        begin
            for (int i = nbytes; i < 4; i++)
                val[8*i +: 8] = 8'hFF;
        end
        return val;
    endfunction

    task automatic store_model(mem_req_t r);
        byte_addr_t a;
        for (int i = 0; i < byte_count(r.size); i++)
        begin
            a = r.addr + byte_addr_t'(i);
            model[a] = r.wdata[8*i +: 8];
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // Responses first, so a load accepted at this edge queues behind them
            if (rsp_valid && expected_q.size() == 0)
            begin
                $display("Response 0x%08h arrived with no load outstanding", rsp.rdata);
                errors++;
            end
            else if (rsp_valid)
            begin
                exp_data = expected_q.pop_front();
                if (rsp.rdata !== exp_data)
                begin
                    $display("Error rsp.rdata: expected 0x%08h, got 0x%08h", exp_data, rsp.rdata);
                    errors++;
                end
            end
            if (req_valid && req.op == OP_STORE)
                store_model(req);
            else if (req_valid)
                expected_q.push_back(expected_load(req));
            if (run_end && expected_q.size() != 0)
            begin
                $display("Run ended with %0d loads still waiting for a response",
                         expected_q.size());
                errors++;
            end
            pending = expected_q.size();
        end
    end

endmodule

`default_nettype wire

// File: dv/data_mem_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_unit_tb;

    import mem_geometry_pkg::*;
    import mem_txn_pkg::*;

    localparam int SEED         = 32'h115c_7603;
    localparam int RANDOM_REQS  = 160;
    // Fill and readback, sign, partial stores, wrap, random mix
    localparam int TOTAL_REQS   = 128 + 14 + 7 + 7 + RANDOM_REQS;
    localparam int TIMEOUT_NS   = 20 * TOTAL_REQS + 4000;
    localparam int DRAIN_CYCLES = 500;

    logic     clk        = 1'b0;
    logic     rsp_credit = 1'b0;
    logic     reset;
    logic     req_valid;
    mem_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    mem_rsp_t rsp;
    logic     run_end;
    int       chk_errors;
    int       loads_pending;

    // Credit and consumer bookkeeping, one writer per counter
    int   credits_spent    = 0;
    int   credits_returned = 0;
    int   rsp_received     = 0;
    int   rsp_released     = 0;
    int   release_wait     = 0;
    logic long_holds       = 1'b0;
    int   tb_errors        = 0;
    int   errors_before    = 0;
    int   tests_run        = 0;

    always #2 clk = ~clk;

    data_mem_unit i_dut (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    data_mem_checker i_checker (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .run_end       (run_end),
        .error_count   (chk_errors),
        .loads_pending (loads_pending)
    );

    always @(posedge clk)
    begin
        if (!reset && req_credit)
            credits_returned++;
        if (!reset && rsp_valid)
            rsp_received++;
    end

    //////////////////////////////
    // Response consumer
    //////////////////////////////

    // Mostly quick releases; the back-pressure test adds long holds
    function automatic int hold_delay();
        if (long_holds && $urandom_range(3, 0) == 0)
            return 16 + int'($urandom_range(23, 0));
        return int'($urandom_range(2, 0));
    endfunction

    always @(negedge clk)
    begin
        rsp_credit = 1'b0;
        if (!reset && rsp_received > rsp_released)
        begin
            if (release_wait == 0)
            begin
                rsp_credit = 1'b1;
                rsp_released++;
                release_wait = hold_delay();
            end
            else
                release_wait--;
        end
    end

    //////////////////////////////
    // Requester
    //////////////////////////////

    function automatic int credits_avail();
        return REQ_QUEUE_DEPTH - credits_spent + credits_returned;
    endfunction

    function automatic logic is_idle();
        return credits_avail() == REQ_QUEUE_DEPTH && loads_pending == 0
               && rsp_received == rsp_released;
    endfunction

    function automatic mem_byte_t fill_byte(byte_addr_t a);
        return {a[3:0], a[7:4]} ^ 8'h5C;
    endfunction

    task automatic send_req(input mem_op_t op, input access_size_t size, input logic sign,
                            input byte_addr_t addr, input word_t wdata);
        while (credits_avail() == 0)
            @(negedge clk);
        req_valid  = 1'b1;
        req.op     = op;
        req.size   = size;
        req.sign   = sign;
        req.addr   = addr;
        req.wdata  = wdata;
        credits_spent++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic store_word(input byte_addr_t addr, input word_t wdata);
        send_req(OP_STORE, SIZE_WORD, 1'b0, addr, wdata);
    endtask

    task automatic issue_load(input access_size_t size, input logic sign, input byte_addr_t addr);
        send_req(OP_LOAD, size, sign, addr, '0);
    endtask

    task automatic finish_test(input string name);
        int cycles;
        int n;
        cycles = 0;
        while (!is_idle() && cycles < DRAIN_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!is_idle())
        begin
            $display("Test %0d (%s) did not drain within %0d cycles",
                     tests_run + 1, name, DRAIN_CYCLES);
            tb_errors++;
        end
        tests_run++;
        n = chk_errors + tb_errors - errors_before;
        errors_before = chk_errors + tb_errors;
        $display("Test %0d %s: %0d errors", tests_run, name, n);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        byte_addr_t base;
        int         total;
        void'($urandom(SEED));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        run_end   = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int w = 0; w < MEM_BYTES / 4; w++)
        begin
            base = byte_addr_t'(4 * w);
            store_word(base, {fill_byte(base + 8'd3), fill_byte(base + 8'd2),
                              fill_byte(base + 8'd1), fill_byte(base)});
        end
        for (int w = 0; w < MEM_BYTES / 4; w++)
            issue_load(SIZE_WORD, 1'b0, byte_addr_t'(4 * w));
        finish_test("full fill and word readback");

        // Bytes 80..83 at 16 have bit 7 set, 10..40 at 20 have it clear
        store_word(8'd16, 32'h8382_8180);
        store_word(8'd20, 32'h4030_2010);
        for (int j = 0; j < 2; j++)
            for (int s = 0; s < 3; s++)
                for (int g = 0; g < 2; g++)
                    issue_load(access_size_t'(2'(s)), 1'(g), byte_addr_t'(16 + 4 * j));
        finish_test("sizes and sign extension");

        send_req(OP_STORE, SIZE_BYTE, 1'b0, 8'd41, 32'hDEAD_BEEF);
        send_req(OP_STORE, SIZE_HALF, 1'b0, 8'd45, 32'hDEAD_BEEF);
        send_req(OP_STORE, SIZE_THREE, 1'b0, 8'd50, 32'hDEAD_BEEF);
        for (int w = 10; w < 14; w++)
            issue_load(SIZE_WORD, 1'b0, byte_addr_t'(4 * w));
        finish_test("partial stores");

        // Lanes past byte 255 land on 0, 1, 2
        store_word(8'd254, 32'h1122_3344);
        send_req(OP_STORE, SIZE_HALF, 1'b0, 8'd255, 32'h0000_A0B0);
        issue_load(SIZE_WORD, 1'b0, 8'd253);
        issue_load(SIZE_WORD, 1'b0, 8'd0);
        issue_load(SIZE_THREE, 1'b1, 8'd254);
        issue_load(SIZE_HALF, 1'b1, 8'd255);
        issue_load(SIZE_WORD, 1'b0, 8'd255);
        finish_test("address wrap");

        long_holds = 1'b1;
        for (int n = 0; n < RANDOM_REQS; n++)
            send_req(mem_op_t'(1'($urandom)), access_size_t'(2'($urandom)), 1'($urandom),
                     byte_addr_t'($urandom), $urandom);
        finish_test("ordering under back-pressure");
        long_holds = 1'b0;

        // A stray credit pulse after the drain would show up here
        repeat (4) @(negedge clk);
        if (credits_avail() != REQ_QUEUE_DEPTH)
        begin
            $display("Requester holds %0d credits at the end instead of %0d",
                     credits_avail(), REQ_QUEUE_DEPTH);
            tb_errors++;
        end
        finish_test("credit conservation");

        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
        total = chk_errors + tb_errors;
        $display("Summary: %0d tests run, %0d errors in total", tests_run, total);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: data_mem_unit.f
source/mem_geometry_pkg.sv
source/mem_txn_pkg.sv
source/lsu_request_queue.sv
source/mem_access_engine.sv
source/byte_lane_ram.sv
source/data_mem_unit.sv
dv/data_mem_checker.sv
dv/data_mem_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module data_mem_unit_tb \
    -f data_mem_unit.f -o data_mem_unit_sim

# Exit status of the pipe is the one of tee, so a failed run still reaches the grep
./obj_dir/data_mem_unit_sim | tee sim.log
grep -qx "No errors" sim.log
